//--- all.f
+incdir+testbench
src/cdp_mul_pkg.sv
src/cdp_mul_operand_if.sv
src/cdp_mul_decode.sv
src/cdp_mul_lane.sv
src/cdp_mul_execute.sv
src/cdp_mul_result.sv
src/cdp_mul.sv
testbench/tb_cdp_mul.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the cdp multiply testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal --top-module tb_cdp_mul -f all.f \
  && ./obj_dir/Vtb_cdp_mul > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "compile or run step failed"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log \
  && { echo "simulation reported failure"; exit 1; } \
  || echo "simulation reported no failure"

//--- testbench/tb_cdp_mul_ref.svh
////////////////////////////////////////
// cdp multiply reference model
////////////////////////////////////////

`ifndef TB_CDP_MUL_REF_SVH
`define TB_CDP_MUL_REF_SVH

logic [31:0] lfsr_state = 32'hf9f8c3e1;

// fibonacci lfsr, taps 32 22 2 1, one step per bit
function automatic logic next_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// signed products per lane, int8 packs two 25 bit fields
function automatic logic [cdp_mul_pkg::OUT_PD_W-1:0] expect_mul(
  input logic [cdp_mul_pkg::SYNC_PD_W-1:0]                    sync_pd,
  input logic [cdp_mul_pkg::INTP_NUM*cdp_mul_pkg::INTP_W-1:0] intp_pd,
  input logic                                                 int8
);
  logic [cdp_mul_pkg::OUT_PD_W-1:0] res;
  logic signed [7:0]                d_lo;
  logic signed [7:0]                d_hi;
  logic signed [15:0]               d_w;
  logic signed [cdp_mul_pkg::INTP_W-1:0] i_lo;
  logic signed [cdp_mul_pkg::INTP_W-1:0] i_hi;
  longint                           p_lo;
  longint                           p_hi;
  res = '0;
  for (int k = 0; k < cdp_mul_pkg::LANE_NUM; k++) begin
    d_lo = sync_pd[k*cdp_mul_pkg::DATIN_W +: 8];
    d_hi = sync_pd[k*cdp_mul_pkg::DATIN_W + 8 +: 8];
    d_w  = sync_pd[k*cdp_mul_pkg::DATIN_W +: 16];
    i_lo = intp_pd[k*cdp_mul_pkg::INTP_W +: cdp_mul_pkg::INTP_W];
    i_hi = intp_pd[(k+4)*cdp_mul_pkg::INTP_W +: cdp_mul_pkg::INTP_W];
    p_lo = int8 ? longint'(d_lo) * longint'(i_lo) : longint'(d_w) * longint'(i_lo);
    p_hi = longint'(d_hi) * longint'(i_hi);
    res[k*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W] =
      int8 ? {p_hi[24:0], p_lo[24:0]} : p_lo[49:0];
  end
  return res;
endfunction

// interpolated values sign extended into the lane fields
function automatic logic [cdp_mul_pkg::OUT_PD_W-1:0] expect_bypass(
  input logic [cdp_mul_pkg::INTP_NUM*cdp_mul_pkg::INTP_W-1:0] intp_pd,
  input logic                                                 int8
);
  logic [cdp_mul_pkg::OUT_PD_W-1:0]      res;
  logic signed [cdp_mul_pkg::INTP_W-1:0] v_lo;
  logic signed [cdp_mul_pkg::INTP_W-1:0] v_hi;
  longint                                e_lo;
  longint                                e_hi;
  res = '0;
  for (int k = 0; k < cdp_mul_pkg::LANE_NUM; k++) begin
    v_lo = intp_pd[k*cdp_mul_pkg::INTP_W +: cdp_mul_pkg::INTP_W];
    v_hi = intp_pd[(k+4)*cdp_mul_pkg::INTP_W +: cdp_mul_pkg::INTP_W];
    e_lo = longint'(v_lo);
    e_hi = longint'(v_hi);
    res[k*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W] =
      int8 ? {e_hi[24:0], e_lo[24:0]} : e_lo[49:0];
  end
  return res;
endfunction

`endif

//--- testbench/tb_cdp_mul.sv
////////////////////////////////////////
// cdp multiply stage testbench
////////////////////////////////////////

`timescale 1ns/1ps

module tb_cdp_mul;

  localparam int PHASE_ITEMS = 40;
  localparam int N_ITEMS     = 7 * PHASE_ITEMS;
  localparam int TIMEOUT_CYC = N_ITEMS * 20 + 200;

  logic                                                 nvdla_core_clk;
  logic                                                 nvdla_core_rstn;
  logic                                                 reg2dp_mul_bypass;
  logic [1:0]                                           reg2dp_input_data_type;
  logic                                                 sync2mul_pvld;
  logic                                                 sync2mul_prdy;
  logic [cdp_mul_pkg::SYNC_PD_W-1:0]                    sync2mul_pd;
  logic                                                 intp2mul_pvld;
  logic                                                 intp2mul_prdy;
  logic [cdp_mul_pkg::INTP_NUM*cdp_mul_pkg::INTP_W-1:0] intp2mul_pd;
  logic                                                 mul2ocvt_pvld;
  logic                                                 mul2ocvt_prdy;
  logic [cdp_mul_pkg::OUT_PD_W-1:0]                     mul2ocvt_pd;

  logic [cdp_mul_pkg::OUT_PD_W-1:0] exp_q [$];  // scoreboard
  logic [cdp_mul_pkg::OUT_PD_W-1:0] exp_head = '0;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] exp_next = '0;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] last_pd  = '0;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] prev_pd  = '0;
  logic in_acc    = 1'b0;
  logic part_xfer = 1'b0;
  logic out_acc   = 1'b0;
  logic cur_byp   = 1'b0;
  logic cur_int8  = 1'b0;
  logic stall_en  = 1'b0;
  int   sb_count  = 0;
  int   errors    = 0;
  int   n_in      = 0;
  int   n_out     = 0;

  `include "tb_cdp_mul_ref.svh"

  cdp_mul i_cdp_mul (.*);

  initial begin
    nvdla_core_clk = 1'b0;
    forever #5 nvdla_core_clk = ~nvdla_core_clk;
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge nvdla_core_clk);
    $display("watchdog expired, %0d items accepted, %0d delivered", n_in, n_out);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // monitor and scoreboard
  ////////////////////////////////////////
  // handshakes are stable half a cycle after the drive point
  always @(negedge nvdla_core_clk) begin
    in_acc    = sync2mul_pvld && sync2mul_prdy && intp2mul_pvld && intp2mul_prdy;
    part_xfer = (sync2mul_pvld && sync2mul_prdy) || (intp2mul_pvld && intp2mul_prdy);
    out_acc   = mul2ocvt_pvld && mul2ocvt_prdy;
    prev_pd   = last_pd;
    last_pd   = mul2ocvt_pd;
    exp_next  = cur_byp ? expect_bypass(intp2mul_pd, cur_int8)
                        : expect_mul(sync2mul_pd, intp2mul_pd, cur_int8);
  end

  always @(posedge nvdla_core_clk) begin
    if (in_acc) begin
      exp_q.push_back(exp_next);
      n_in++;
    end
    if (out_acc && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      n_out++;
    end
    sb_count = exp_q.size();
    exp_head = (sb_count > 0) ? exp_q[0] : '0;
  end

  task automatic note_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  a_rst_pvld: assert property (@(posedge nvdla_core_clk) !nvdla_core_rstn |-> !mul2ocvt_pvld)
    else note_error($sformatf("** Error at %0t: mul2ocvt_pvld expected 0 got %b",
                              $time, $sampled(mul2ocvt_pvld)));
  a_sync_join: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
                                sync2mul_prdy |-> intp2mul_pvld)
    else note_error($sformatf("** Error at %0t: sync2mul_prdy expected 0 got 1", $time));
  a_intp_join: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
                                intp2mul_prdy |-> sync2mul_pvld)
    else note_error($sformatf("** Error at %0t: intp2mul_prdy expected 0 got 1", $time));
  a_no_extra: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
                               mul2ocvt_pvld |-> sb_count > 0)
    else note_error($sformatf("** Error at %0t: mul2ocvt_pvld expected 0 got 1 %s",
                              $time, "with no accepted item outstanding"));
  a_payload: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
                              (mul2ocvt_pvld && mul2ocvt_prdy) |-> mul2ocvt_pd == exp_head)
    else note_error($sformatf("** Error at %0t: mul2ocvt_pd expected %h got %h",
                              $time, $sampled(exp_head), $sampled(mul2ocvt_pd)));
  a_hold: assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
                           (mul2ocvt_pvld && !mul2ocvt_prdy) |=>
                           (mul2ocvt_pvld && mul2ocvt_pd == prev_pd))
    else note_error($sformatf("** Error at %0t: mul2ocvt_pd expected %h got %h, pvld %b",
                              $time, $sampled(prev_pd), $sampled(mul2ocvt_pd),
                              $sampled(mul2ocvt_pvld)));

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  task automatic step_cycle();
    @(posedge nvdla_core_clk);
    #1;
    mul2ocvt_prdy = stall_en ? next_bit() : 1'b1;  // random stall
  endtask

  task automatic load_item();
    for (int i = 0; i < cdp_mul_pkg::SYNC_PD_W; i++) begin
      sync2mul_pd[i] = next_bit();
    end
    for (int i = 0; i < cdp_mul_pkg::INTP_NUM*cdp_mul_pkg::INTP_W; i++) begin
      intp2mul_pd[i] = next_bit();
    end
    sync2mul_pvld = next_bit();
    intp2mul_pvld = next_bit();
  endtask

  task automatic run_phase(input logic byp, input cdp_mul_pkg::data_type_e dtype,
                           input logic stall);
    int accepted;
    accepted               = 0;
    stall_en               = stall;
    reg2dp_mul_bypass      = byp;
    reg2dp_input_data_type = dtype;
    cur_byp                = byp;
    cur_int8               = (dtype == cdp_mul_pkg::DT_INT8);
    repeat (2) step_cycle();  // mode flops settle
    load_item();
    while (accepted < PHASE_ITEMS) begin
      step_cycle();
      if (in_acc) begin
        accepted++;
        sync2mul_pvld = 1'b0;
        intp2mul_pvld = 1'b0;
        if (accepted < PHASE_ITEMS) load_item();
      end else begin
        // streams go valid independently and then hold
        if (!sync2mul_pvld) sync2mul_pvld = next_bit();
        if (!intp2mul_pvld) intp2mul_pvld = next_bit();
      end
    end
    while (sb_count > 0) step_cycle();
  endtask

  task automatic check_one_stream();
    stall_en = 1'b0;
    load_item();
    sync2mul_pvld = 1'b1;
    intp2mul_pvld = 1'b0;
    for (int c = 0; c < 24; c++) begin
      if (c == 12) begin
        sync2mul_pvld = 1'b0;
        intp2mul_pvld = 1'b1;
      end
      step_cycle();
      if (part_xfer) note_error($sformatf("%0t: item taken with one stream valid", $time));
    end
    intp2mul_pvld = 1'b0;
    repeat (4) step_cycle();
  endtask

  initial begin
    nvdla_core_rstn        = 1'b0;
    reg2dp_mul_bypass      = 1'b0;
    reg2dp_input_data_type = cdp_mul_pkg::DT_INT16;
    sync2mul_pvld          = 1'b0;
    sync2mul_pd            = '0;
    intp2mul_pvld          = 1'b0;
    intp2mul_pd            = '0;
    mul2ocvt_prdy          = 1'b0;
    repeat (4) @(posedge nvdla_core_clk);
    #1 nvdla_core_rstn = 1'b1;
    repeat (3) step_cycle();

    run_phase(1'b0, cdp_mul_pkg::DT_INT16, 1'b0);
    run_phase(1'b0, cdp_mul_pkg::DT_INT8,  1'b0);
    run_phase(1'b1, cdp_mul_pkg::DT_INT8,  1'b0);
    run_phase(1'b1, cdp_mul_pkg::DT_FP16,  1'b0);  // same as int16
    run_phase(1'b0, cdp_mul_pkg::DT_INT16, 1'b1);
    run_phase(1'b0, cdp_mul_pkg::DT_INT8,  1'b1);
    run_phase(1'b1, cdp_mul_pkg::DT_INT8,  1'b1);
    check_one_stream();

    if (n_in != N_ITEMS || n_out != n_in) begin
      note_error($sformatf("item count mismatch, %0d accepted and %0d delivered", n_in, n_out));
    end
    $display("errors: %0d, items accepted: %0d, items delivered: %0d", errors, n_in, n_out);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- src/cdp_mul.sv
////////////////////////////////////////
// cdp multiply stage top
////////////////////////////////////////

`timescale 1ns/1ps

module cdp_mul (
  input  logic                                                 nvdla_core_clk,
  input  logic                                                 nvdla_core_rstn,
  input  logic                                                 reg2dp_mul_bypass,
  input  logic [1:0]                                           reg2dp_input_data_type,
  input  logic                                                 sync2mul_pvld,
  output logic                                                 sync2mul_prdy,
  input  logic [cdp_mul_pkg::SYNC_PD_W-1:0]                    sync2mul_pd,
  input  logic                                                 intp2mul_pvld,
  output logic                                                 intp2mul_prdy,
  input  logic [cdp_mul_pkg::INTP_NUM*cdp_mul_pkg::INTP_W-1:0] intp2mul_pd,
  output logic                                                 mul2ocvt_pvld,
  input  logic                                                 mul2ocvt_prdy,
  output logic [cdp_mul_pkg::OUT_PD_W-1:0]                     mul2ocvt_pd
);

  logic                             res_rdy;
  logic                             byp_vld;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] byp_pd;
  logic                             mul_vld;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] mul_pd;

  cdp_mul_operand_if op_if ();

  ////////////////////////////////////////
  // join and mode control
  ////////////////////////////////////////
  cdp_mul_decode u_decode (
    .nvdla_core_clk         (nvdla_core_clk),
    .nvdla_core_rstn        (nvdla_core_rstn),
    .reg2dp_mul_bypass      (reg2dp_mul_bypass),
    .reg2dp_input_data_type (cdp_mul_pkg::data_type_e'(reg2dp_input_data_type)),
    .sync2mul_pvld          (sync2mul_pvld),
    .sync2mul_pd            (sync2mul_pd),
    .sync2mul_prdy          (sync2mul_prdy),
    .intp2mul_pvld          (intp2mul_pvld),
    .intp2mul_pd            (intp2mul_pd),
    .intp2mul_prdy          (intp2mul_prdy),
    .res_rdy                (res_rdy),
    .byp_vld                (byp_vld),
    .byp_pd                 (byp_pd),
    .op                     (op_if.decode_mp)
  );

  // four lanes, one item deep
  cdp_mul_execute u_execute (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op              (op_if.execute_mp),
    .mul_vld         (mul_vld),
    .mul_rdy         (res_rdy),        // shared with the bypass path
    .mul_pd          (mul_pd)
  );

  ////////////////////////////////////////
  // output select, skid and pipe
  ////////////////////////////////////////
  cdp_mul_result u_result (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .mul_vld         (mul_vld),
    .mul_pd          (mul_pd),
    .byp_vld         (byp_vld),
    .byp_pd          (byp_pd),
    .res_rdy         (res_rdy),
    .mul2ocvt_pvld   (mul2ocvt_pvld),
    .mul2ocvt_pd     (mul2ocvt_pd),
    .mul2ocvt_prdy   (mul2ocvt_prdy)
  );

endmodule

//--- src/cdp_mul_result.sv
////////////////////////////////////////
// cdp multiply output stage
////////////////////////////////////////

`timescale 1ns/1ps

module cdp_mul_result (
  input  logic                             nvdla_core_clk,
  input  logic                             nvdla_core_rstn,
  input  logic                             mul_vld,
  input  logic [cdp_mul_pkg::OUT_PD_W-1:0] mul_pd,
  input  logic                             byp_vld,
  input  logic [cdp_mul_pkg::OUT_PD_W-1:0] byp_pd,
  output logic                             res_rdy,
  output logic                             mul2ocvt_pvld,
  output logic [cdp_mul_pkg::OUT_PD_W-1:0] mul2ocvt_pd,
  input  logic                             mul2ocvt_prdy
);

  logic                             in_vld;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] in_pd;

  logic                             skid_catch;
  logic                             skid_ready;
  logic                             skid_ready_flop;
  logic                             skid_valid;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] skid_data;
  logic                             skid_pipe_valid;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] skid_pipe_data;
  logic                             skid_pipe_ready;

  logic                             pipe_valid;
  logic [cdp_mul_pkg::OUT_PD_W-1:0] pipe_data;
  logic                             pipe_ready_bc;

  // only one source is live for a given mode
  assign in_vld = mul_vld | byp_vld;
  assign in_pd  = byp_vld ? byp_pd : mul_pd;

  ////////////////////////////////////////
  // skid buffer
  ////////////////////////////////////////
  // upstream saw ready high, but the pipe is full
  assign skid_catch = in_vld & skid_ready_flop & ~skid_pipe_ready;
  assign skid_ready = skid_valid ? skid_pipe_ready : ~skid_catch;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid      <= 1'b0;
      skid_ready_flop <= 1'b1;
    end else begin
      skid_valid      <= skid_valid ? ~skid_pipe_ready : skid_catch;
      skid_ready_flop <= skid_ready;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_data <= in_pd;
    end
  end

  assign res_rdy = skid_ready_flop;  // flopped ready back to decode and execute

  assign skid_pipe_valid = skid_ready_flop ? in_vld : skid_valid;
  assign skid_pipe_data  = skid_ready_flop ? in_pd : skid_data;

  ////////////////////////////////////////
  // output pipe, bubble collapsing
  ////////////////////////////////////////
  assign pipe_ready_bc   = mul2ocvt_prdy | ~pipe_valid;
  assign skid_pipe_ready = pipe_ready_bc;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else begin
      pipe_valid <= pipe_ready_bc ? skid_pipe_valid : 1'b1;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && skid_pipe_valid) begin
      pipe_data <= skid_pipe_data;
    end
  end

  assign mul2ocvt_pvld = pipe_valid;
  assign mul2ocvt_pd   = pipe_data;

endmodule

//--- src/cdp_mul_execute.sv
////////////////////////////////////////
// cdp multiply execute stage
////////////////////////////////////////

`timescale 1ns/1ps

module cdp_mul_execute (
  input  logic                             nvdla_core_clk,
  input  logic                             nvdla_core_rstn,
  cdp_mul_operand_if.execute_mp            op,
  output logic                             mul_vld,
  input  logic                             mul_rdy,
  output logic [cdp_mul_pkg::OUT_PD_W-1:0] mul_pd
);

  logic load;

  // one item deep, refill in the cycle it drains
  assign op.rdy = ~mul_vld | mul_rdy;
  assign load   = op.vld & op.rdy;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      mul_vld <= 1'b0;
    end else begin
      mul_vld <= load | (mul_vld & ~mul_rdy);
    end
  end

  ////////////////////////////////////////
  // lanes
  ////////////////////////////////////////
  cdp_mul_lane u_lane0 (
    .nvdla_core_clk (nvdla_core_clk),
    .load           (load),
    .int8_en        (op.int8_en),
    .opnd           (op.ops[0]),
    .pd             (mul_pd[0*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W])
  );

  cdp_mul_lane u_lane1 (
    .nvdla_core_clk (nvdla_core_clk),
    .load           (load),
    .int8_en        (op.int8_en),
    .opnd           (op.ops[1]),
    .pd             (mul_pd[1*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W])
  );

  cdp_mul_lane u_lane2 (
    .nvdla_core_clk (nvdla_core_clk),
    .load           (load),
    .int8_en        (op.int8_en),
    .opnd           (op.ops[2]),
    .pd             (mul_pd[2*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W])
  );

  cdp_mul_lane u_lane3 (
    .nvdla_core_clk (nvdla_core_clk),
    .load           (load),
    .int8_en        (op.int8_en),
    .opnd           (op.ops[3]),
    .pd             (mul_pd[3*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W])
  );

endmodule

//--- src/cdp_mul_lane.sv
////////////////////////////////////////
// cdp multiply lane
////////////////////////////////////////

`timescale 1ns/1ps

module cdp_mul_lane (
  input  logic                              nvdla_core_clk,
  input  logic                              load,
  input  logic                              int8_en,
  input  cdp_mul_pkg::lane_operand_t        opnd,
  output logic [cdp_mul_pkg::LANE_PD_W-1:0] pd
);

  logic signed [cdp_mul_pkg::INT8_W-1:0]    dat_lo;
  logic signed [cdp_mul_pkg::INT8_W-1:0]    dat_hi;
  logic signed [cdp_mul_pkg::INT16_W-1:0]   dat_w16;
  logic signed [cdp_mul_pkg::INTP_W-1:0]    intp_lo;
  logic signed [cdp_mul_pkg::INTP_W-1:0]    intp_hi;
  logic signed [cdp_mul_pkg::HALF_PD_W-1:0] prod_lo;
  logic signed [cdp_mul_pkg::HALF_PD_W-1:0] prod_hi;
  logic signed [cdp_mul_pkg::LANE_PD_W-1:0] prod_w16;

  assign dat_lo  = opnd.datin[cdp_mul_pkg::INT8_W-1:0];
  assign dat_hi  = opnd.datin[cdp_mul_pkg::INT16_W-1:cdp_mul_pkg::INT8_W];
  assign dat_w16 = opnd.datin[cdp_mul_pkg::INT16_W-1:0];
  assign intp_lo = opnd.intp_lo;
  assign intp_hi = opnd.intp_hi;

  // 8x17 fits in 25 bits, 16x17 widened to the full lane
  assign prod_lo  = dat_lo * intp_lo;
  assign prod_hi  = dat_hi * intp_hi;
  assign prod_w16 = dat_w16 * intp_lo;

  // result register
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      pd <= int8_en ? {prod_hi, prod_lo} : prod_w16;
    end
  end

endmodule

//--- src/cdp_mul_decode.sv
////////////////////////////////////////
// cdp multiply input join
////////////////////////////////////////

`timescale 1ns/1ps

module cdp_mul_decode (
  input  logic                                                     nvdla_core_clk,
  input  logic                                                     nvdla_core_rstn,
  input  logic                                                     reg2dp_mul_bypass,
  input  cdp_mul_pkg::data_type_e                                  reg2dp_input_data_type,
  input  logic                                                     sync2mul_pvld,
  input  logic [cdp_mul_pkg::SYNC_PD_W-1:0]                        sync2mul_pd,
  output logic                                                     sync2mul_prdy,
  input  logic                                                     intp2mul_pvld,
  input  logic [cdp_mul_pkg::INTP_NUM*cdp_mul_pkg::INTP_W-1:0]     intp2mul_pd,
  output logic                                                     intp2mul_prdy,
  input  logic                                                     res_rdy,
  output logic                                                     byp_vld,
  output logic [cdp_mul_pkg::OUT_PD_W-1:0]                         byp_pd,
  cdp_mul_operand_if.decode_mp                                     op
);

  logic mul_bypass_en;
  logic int8_en;
  logic in_vld;
  logic sel_rdy;

  ////////////////////////////////////////
  // mode registers
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      mul_bypass_en <= 1'b0;
      int8_en       <= 1'b0;
    end else begin
      mul_bypass_en <= reg2dp_mul_bypass;
      int8_en       <= (reg2dp_input_data_type == cdp_mul_pkg::DT_INT8);
    end
  end

  // both streams are taken together
  assign in_vld  = sync2mul_pvld & intp2mul_pvld;
  assign sel_rdy = mul_bypass_en ? res_rdy : op.rdy;

  assign sync2mul_prdy = sel_rdy & intp2mul_pvld;
  assign intp2mul_prdy = sel_rdy & sync2mul_pvld;

  assign byp_vld    = mul_bypass_en & in_vld;
  assign op.vld     = ~mul_bypass_en & in_vld;
  assign op.int8_en = int8_en;

  ////////////////////////////////////////
  // lane slicing and bypass packing
  ////////////////////////////////////////
  for (genvar k = 0; k < cdp_mul_pkg::LANE_NUM; k++) begin : g_lane
    logic [cdp_mul_pkg::INTP_W-1:0]    val_lo;
    logic [cdp_mul_pkg::INTP_W-1:0]    val_hi;
    logic [cdp_mul_pkg::HALF_PD_W-1:0] byp_lo;
    logic [cdp_mul_pkg::HALF_PD_W-1:0] byp_hi;
    logic [cdp_mul_pkg::LANE_PD_W-1:0] byp_w16;

    assign val_lo = intp2mul_pd[k*cdp_mul_pkg::INTP_W +: cdp_mul_pkg::INTP_W];
    assign val_hi = intp2mul_pd[(k+cdp_mul_pkg::LANE_NUM)*cdp_mul_pkg::INTP_W
                                +: cdp_mul_pkg::INTP_W];

    assign op.ops[k] = {sync2mul_pd[k*cdp_mul_pkg::DATIN_W +: cdp_mul_pkg::DATIN_W],
                        val_lo, val_hi};

    // sign extend values into the result fields
    assign byp_lo  = {{(cdp_mul_pkg::HALF_PD_W-cdp_mul_pkg::INTP_W){val_lo[cdp_mul_pkg::INTP_W-1]}},
                      val_lo};
    assign byp_hi  = {{(cdp_mul_pkg::HALF_PD_W-cdp_mul_pkg::INTP_W){val_hi[cdp_mul_pkg::INTP_W-1]}},
                      val_hi};
    assign byp_w16 = {{(cdp_mul_pkg::LANE_PD_W-cdp_mul_pkg::INTP_W){val_lo[cdp_mul_pkg::INTP_W-1]}},
                      val_lo};

    assign byp_pd[k*cdp_mul_pkg::LANE_PD_W +: cdp_mul_pkg::LANE_PD_W] =
      int8_en ? {byp_hi, byp_lo} : byp_w16;
  end

endmodule

//--- src/cdp_mul_operand_if.sv
////////////////////////////////////////
// decode to execute operands
////////////////////////////////////////

`timescale 1ns/1ps

interface cdp_mul_operand_if;

  logic                       vld;
  logic                       rdy;
  logic                       int8_en;  // registered mode flag
  cdp_mul_pkg::lane_operand_t ops [cdp_mul_pkg::LANE_NUM];

  // item moves on a rising edge with vld and rdy high
  modport decode_mp (
    output vld,
    output ops,
    output int8_en,
    input  rdy
  );

  modport execute_mp (
    input  vld,
    input  ops,
    input  int8_en,
    output rdy
  );

endinterface

//--- src/cdp_mul_pkg.sv
////////////////////////////////////////
// cdp multiply stage shared types
////////////////////////////////////////

package cdp_mul_pkg;

  ////////////////////////////////////////
  // lane and stream geometry
  ////////////////////////////////////////
  localparam int LANE_NUM  = 4;        // multiply lanes
  localparam int INTP_NUM  = 8;        // lane k owns values k and k+4
  localparam int INTP_W    = 17;       // signed interpolated value
  localparam int DATIN_W   = 18;       // one lane slot of sync data
  localparam int SYNC_PD_W = LANE_NUM * DATIN_W;

  // operand widths inside a lane slot
  localparam int INT8_W  = 8;
  localparam int INT16_W = 16;

  ////////////////////////////////////////
  // result geometry
  ////////////////////////////////////////
  localparam int HALF_PD_W = 25;       // one int8 product field
  localparam int LANE_PD_W = 2 * HALF_PD_W;
  localparam int OUT_PD_W  = LANE_NUM * LANE_PD_W;

  // input data type, fp16 is handled as int16
  typedef enum logic [1:0] {
    DT_INT8  = 2'd0,
    DT_INT16 = 2'd1,
    DT_FP16  = 2'd2
  } data_type_e;

  // per lane operand set handed from decode to execute
  typedef struct packed {
    logic        [DATIN_W-1:0] datin;    // sync slot
    logic signed [INTP_W-1:0]  intp_lo;  // value k
    logic signed [INTP_W-1:0]  intp_hi;  // value k+4, int8 only
  } lane_operand_t;

endpackage
